// ==== project.f ====
hub75_pkg.sv
countdown_timer.sv
bit_plane_timer.sv
matrix_scan.sv
frame_buffer.sv
pixel_fetch.sv
hub75_top.sv
tb_hub75_top.sv

// ==== Bender.yml ====
package:
  name: hub75_driver

sources:
  - files:
      - hub75_pkg.sv
      - countdown_timer.sv
      - bit_plane_timer.sv
      - matrix_scan.sv
      - frame_buffer.sv
      - pixel_fetch.sv
      - hub75_top.sv
  - target: simulation
    files:
      - tb_hub75_top.sv

// ==== hub75_stim.txt ====
// pixel writes from @00: valid_half_row_column_pixel, pixel is red green blue in 4 bits each
// expected planes from @40: bitindex_ontime, in display order
@00
1_0_0_f_fff
1_1_0_f_000
1_0_0_0_f00
1_1_0_0_0f0
1_0_1_7_00f
1_1_1_8_a5c
1_0_2_3_842
1_1_2_c_218
1_0_3_0_fff
1_1_3_f_123
1_0_3_0_000
1_0_0_f_8c3
@40
3_0040
2_0020
1_0010
0_0008

// ==== tb_hub75_top.sv ====
/*
 * Testbench for the HUB75 driver top level
 * loads the frame from the stim file and checks the panel pins against a model
 */
`default_nettype none

module tb_hub75_top import hub75_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half = 4;
    localparam int timeout_cycles = 20000;
    // plane entries start here in the stim memory
    localparam int plane_base = 'h40;
    // two full frames
    localparam int total_planes = 2 * panel_halfheight * brightness_levels;

    logic                clk_in;
    logic                reset;
    host_wr_t            host_wr;
    rgb_pins_t           rgb;
    logic                pixel_clk;
    logic                row_latch;
    logic                output_enable;
    logic [row_bits-1:0] row_address;

    logic [27:0] stim_mem [0:127];
    pixel_t      model_top [panel_halfheight][panel_width];
    pixel_t      model_bottom [panel_halfheight][panel_width];

    integer seed;
    int     errors = 0;
    int     checks = 0;
    logic   timed_out = 1'b0;

    // monitor state, model walk of the plane sequence
    logic      reset_q = 1'b0;
    logic      reset_qq = 1'b0;
    logic      oe_prev = 1'b0;
    logic      row_check_due = 1'b0;
    int        pulse_count = 0;
    int        plane_idx = 0;
    int        model_row = 0;
    int        lit_plane = 0;
    int        lit_row = 0;
    int        oe_count = 0;
    int        ontime_count = 0;
    rgb_pins_t expected;

    hub75_top hub75_top_inst (
        .clk_in       (clk_in),
        .reset        (reset),
        .host_wr      (host_wr),
        .rgb          (rgb),
        .pixel_clk    (pixel_clk),
        .row_latch    (row_latch),
        .output_enable(output_enable),
        .row_address  (row_address)
    );

    always #(clk_half) clk_in = ~clk_in;

    function automatic int plane_bit(input int idx);
        return int'(stim_mem[plane_base + idx][19:16]);
    endfunction

    function automatic int plane_on_time(input int idx);
        return int'(stim_mem[plane_base + idx][15:0]);
    endfunction

    // one bit of every colour in both halves, straight from the model frame
    function automatic rgb_pins_t pins_for(input int row, input int column, input int bit_index);
        pixel_t    top;
        pixel_t    bottom;
        rgb_pins_t pins;
        top = model_top[row][column];
        bottom = model_bottom[row][column];
        pins.r0 = top.red[bit_index];
        pins.g0 = top.green[bit_index];
        pins.b0 = top.blue[bit_index];
        pins.r1 = bottom.red[bit_index];
        pins.g1 = bottom.green[bit_index];
        pins.b1 = bottom.blue[bit_index];
        return pins;
    endfunction

    // single write strobe, model copy updated alongside
    task automatic write_pixel(input logic half, input int row, input int column,
                               input pixel_t pixel);
        @(posedge clk_in);
        #1;
        host_wr.en = 1'b1;
        host_wr.half = half;
        host_wr.row = row_bits'(row);
        host_wr.column = column_bits'(column);
        host_wr.pixel = pixel;
        if (half) begin
            model_bottom[row][column] = pixel;
        end else begin
            model_top[row][column] = pixel;
        end
    endtask

    // pins sampled at the rising edge hold the state of the previous cycle
    always @(posedge clk_in) begin
        if (reset_q || reset_qq) begin
            checks++;
            assert (!pixel_clk && !row_latch && !output_enable && rgb == '0
                    && row_address == '0) else begin
                errors++;
                $display("ERR %0t: panel pins not idle around reset", $time);
            end
        end else if (!reset) begin
            // output enable interval, rises right after a latch
            if (output_enable && !oe_prev) begin
                checks++;
                assert (row_check_due) else begin
                    errors++;
                    $display("ERR %0t: output_enable rose without a latch before it", $time);
                end
            end
            if (output_enable) begin
                oe_count++;
            end else if (oe_prev) begin
                checks++;
                assert (oe_count == plane_on_time(lit_plane)) else begin
                    errors++;
                    $display("ERR %0t: on-time %0d, expected %0d", $time, oe_count,
                             plane_on_time(lit_plane));
                end
                ontime_count++;
                oe_count = 0;
            end
            oe_prev = output_enable;
            // k-th shift clock carries column panel_width-1-k
            if (pixel_clk) begin
                checks++;
                assert (pulse_count < panel_width) else begin
                    errors++;
                    $display("ERR %0t: extra pixel_clk pulse in a plane", $time);
                end
                if (pulse_count < panel_width) begin
                    expected = pins_for(model_row, panel_width - 1 - pulse_count,
                                        plane_bit(plane_idx));
                    assert (rgb == expected) else begin
                        errors++;
                        $display("ERR %0t: rgb %b, expected %b at row %0d column %0d", $time,
                                 rgb, expected, model_row, panel_width - 1 - pulse_count);
                    end
                end
                pulse_count++;
            end
            if (row_latch) begin
                checks++;
                assert (pulse_count == panel_width) else begin
                    errors++;
                    $display("ERR %0t: %0d pixel_clk pulses before latch, expected %0d",
                             $time, pulse_count, panel_width);
                end
                assert (!output_enable) else begin
                    errors++;
                    $display("ERR %0t: row_latch while output_enable is high", $time);
                end
                lit_plane = plane_idx;
                lit_row = model_row;
                row_check_due = 1'b1;
                pulse_count = 0;
                // msb to lsb, then the next row pair
                if (plane_idx == brightness_levels - 1) begin
                    plane_idx = 0;
                    model_row = (model_row + 1) % panel_halfheight;
                end else begin
                    plane_idx++;
                end
            end else if (row_check_due) begin
                checks++;
                assert (row_address == row_bits'(lit_row)) else begin
                    errors++;
                    $display("ERR %0t: row_address %0d, expected %0d", $time, row_address,
                             lit_row);
                end
                row_check_due = 1'b0;
            end
        end
        reset_qq = reset_q;
        reset_q = reset;
    end

    initial begin
        logic [31:0] rnd;
        int          n;
        int          cycles;
        clk_in = 1'b0;
        reset = 1'b1;
        host_wr = '0;
        seed = 32'hbdc7;
        for (int i = 0; i < 128; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("hub75_stim.txt", stim_mem);
        // stim plane list must walk msb to lsb with weighted on-times
        for (int p = 0; p < brightness_levels; p++) begin
            assert (plane_bit(p) == brightness_levels - 1 - p
                    && plane_on_time(p) == (base_on_cycles << plane_bit(p))) else begin
                errors++;
                $display("stim file plane entry %0d is missing or out of order", p);
            end
        end
        // random frame first, then the stim file writes on top
        for (int h = 0; h < 2; h++) begin
            for (int r = 0; r < panel_halfheight; r++) begin
                for (int c = 0; c < panel_width; c++) begin
                    rnd = $random(seed);
                    write_pixel(h[0], r, c, rnd[11:0]);
                end
            end
        end
        n = 0;
        while (n < plane_base && stim_mem[n][27:24] == 4'h1) begin
            write_pixel(stim_mem[n][20], int'(stim_mem[n][19:16]), int'(stim_mem[n][15:12]),
                        stim_mem[n][11:0]);
            n++;
        end
        @(posedge clk_in);
        #1;
        host_wr = '0;
        repeat (16) @(posedge clk_in);
        #1;
        reset = 1'b0;
        cycles = 0;
        while (ontime_count < total_planes && cycles < timeout_cycles) begin
            @(negedge clk_in);
            cycles++;
        end
        if (ontime_count < total_planes) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d output enable intervals seen", ontime_count,
                     total_planes);
        end
        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hub75_top.sv ====
/*
 * HUB75 LED matrix driver top level
 * scan controller, frame buffer and shifter in a three-stage pipeline
 */
`default_nettype none

module hub75_top import hub75_pkg::*; (
    input  logic                clk_in,
    input  logic                reset,
    input  host_wr_t            host_wr,
    output rgb_pins_t           rgb,
    output logic                pixel_clk,
    output logic                row_latch,
    output logic                output_enable,
    output logic [row_bits-1:0] row_address
);

    scan_cmd_t scan_cmd;
    fetch_t    fetch;

    // row_latch loops back to step the scan sequence
    matrix_scan matrix_scan_inst (
        .clk_in            (clk_in),
        .reset             (reset),
        .row_latch         (row_latch),
        .scan_cmd          (scan_cmd),
        .row_address_active(row_address),
        .output_enable     (output_enable)
    );

    frame_buffer frame_buffer_inst (
        .clk_in  (clk_in),
        .reset   (reset),
        .host_wr (host_wr),
        .scan_cmd(scan_cmd),
        .fetch   (fetch)
    );

    pixel_fetch pixel_fetch_inst (
        .clk_in   (clk_in),
        .reset    (reset),
        .fetch    (fetch),
        .rgb      (rgb),
        .pixel_clk(pixel_clk),
        .row_latch(row_latch)
    );

endmodule

`default_nettype wire

// ==== pixel_fetch.sv ====
/*
 * Bit-plane selector and HUB75 shifter
 * drives rgb data, the shift clock and the row latch
 */
`default_nettype none

module pixel_fetch import hub75_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  fetch_t    fetch,
    output rgb_pins_t rgb,
    output logic      pixel_clk,
    output logic      row_latch
);

    rgb_pins_t rgb_next;

    // flag pipeline behind the data
    logic valid_d;
    logic last_d;
    logic last_dd;

    // pick the plane bit of each colour, one-hot mask so a reduce-or is enough
    always_comb begin
        rgb_next.r0 = |(fetch.top.red & fetch.mask);
        rgb_next.g0 = |(fetch.top.green & fetch.mask);
        rgb_next.b0 = |(fetch.top.blue & fetch.mask);
        rgb_next.r1 = |(fetch.bottom.red & fetch.mask);
        rgb_next.g1 = |(fetch.bottom.green & fetch.mask);
        rgb_next.b1 = |(fetch.bottom.blue & fetch.mask);
    end

    // data pins, held between loads
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb <= '0;
        end else if (fetch.valid) begin
            rgb <= rgb_next;
        end
    end

    // shift clock one cycle after the data, so rgb is stable a full cycle
    // before the panel samples it
    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_d <= 1'b0;
            pixel_clk <= 1'b0;
        end else begin
            valid_d <= fetch.valid;
            pixel_clk <= valid_d;
        end
    end

    // latch follows the last shift clock pulse
    always_ff @(posedge clk_in) begin
        if (reset) begin
            last_d <= 1'b0;
            last_dd <= 1'b0;
            row_latch <= 1'b0;
        end else begin
            last_d <= fetch.valid && fetch.last;
            last_dd <= last_d;
            row_latch <= last_dd;
        end
    end

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
/*
 * Two-bank frame buffer
 * host write port, both halves read together for each scan command
 */
`default_nettype none

module frame_buffer import hub75_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  host_wr_t  host_wr,
    input  scan_cmd_t scan_cmd,
    output fetch_t    fetch
);

    // bank 0 is the top half, bank 1 the bottom
    pixel_t top_bank [panel_halfheight * panel_width];
    pixel_t bottom_bank [panel_halfheight * panel_width];

    logic [row_bits+column_bits-1:0] wr_addr;
    logic [row_bits+column_bits-1:0] rd_addr;

    logic    valid_q;
    logic    last_q;
    colour_t mask_q;
    pixel_t  top_q;
    pixel_t  bottom_q;

    // row major, same layout in both banks
    assign wr_addr = {host_wr.row, host_wr.column};
    assign rd_addr = {scan_cmd.row, scan_cmd.column};

    always_ff @(posedge clk_in) begin
        if (host_wr.en && !host_wr.half) begin
            top_bank[wr_addr] <= host_wr.pixel;
        end
        if (host_wr.en && host_wr.half) begin
            bottom_bank[wr_addr] <= host_wr.pixel;
        end
        // read stage, mask rides along with the data
        if (scan_cmd.valid) begin
            top_q <= top_bank[rd_addr];
            bottom_q <= bottom_bank[rd_addr];
            mask_q <= scan_cmd.mask;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            valid_q <= scan_cmd.valid;
            last_q <= scan_cmd.valid && scan_cmd.last;
        end
    end

    assign fetch = '{valid: valid_q, last: last_q, mask: mask_q, top: top_q, bottom: bottom_q};

endmodule

`default_nettype wire

// ==== matrix_scan.sv ====
/*
 * HUB75 scan controller
 * sequences columns, bit planes msb first and row pairs, keeps the lit row and mask
 */
`default_nettype none

module matrix_scan import hub75_pkg::*; (
    input  logic                clk_in,
    input  logic                reset,
    input  logic                row_latch,
    output scan_cmd_t           scan_cmd,
    output logic [row_bits-1:0] row_address_active,
    output logic                output_enable
);

    // plane being shifted out
    logic [row_bits-1:0] row;
    colour_t             mask;
    // plane currently lit
    colour_t             mask_active;

    logic [1:0] advance;
    logic       state_advance;
    logic       plane_start;
    logic       overlap_ok;

    logic [column_bits+1:0] pace_counter;
    logic                   shifting;
    logic [column_bits:0]   column_counter;
    logic                   column_running;

    logic                   cmd_valid;
    logic [column_bits-1:0] column;

    // next plane may go once the lit one is nearly done
    // shifting blocks a second trigger until this plane's latch is through
    assign state_advance = (!output_enable || overlap_ok) && !shifting;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            advance <= 2'b00;
        end else begin
            advance <= {advance[0], state_advance};
        end
    end

    // rising edge of the advance condition
    assign plane_start = advance[0] && !advance[1];

    // busy window, commands plus four cycles to the latch and its echo
    countdown_timer #(
        .counter_width(column_bits + 2)
    ) pace_timer_inst (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (plane_start),
        .value  ((column_bits + 2)'(2 * panel_width + 4)),
        .counter(pace_counter),
        .running(shifting)
    );

    // two counts per column, upper bits are the column address
    countdown_timer #(
        .counter_width(column_bits + 1)
    ) column_timer_inst (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (plane_start),
        .value  ((column_bits + 1)'(2 * panel_width - 1)),
        .counter(column_counter),
        .running(column_running)
    );

    // pace count is even on every second cycle of the column run
    assign cmd_valid = column_running && !pace_counter[0];
    assign column = column_counter[column_bits:1];

    assign scan_cmd.valid = cmd_valid;
    assign scan_cmd.last = cmd_valid && (column == '0);
    assign scan_cmd.column = column;
    assign scan_cmd.row = row;
    assign scan_cmd.mask = mask;

    // latch hands the shifted plane to the panel and steps the sequence
    always_ff @(posedge clk_in) begin
        if (reset) begin
            row <= '0;
            mask <= colour_t'(1) << (brightness_levels - 1);
            row_address_active <= '0;
            mask_active <= '0;
        end else if (row_latch) begin
            row_address_active <= row;
            mask_active <= mask;
            if (mask[0]) begin
                // lsb done, back to msb on the next row pair
                mask <= colour_t'(1) << (brightness_levels - 1);
                if (row == row_bits'(panel_halfheight - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                mask <= mask >> 1;
            end
        end
    end

    bit_plane_timer bit_plane_timer_inst (
        .clk_in       (clk_in),
        .reset        (reset),
        .row_latch    (row_latch),
        .mask_active  (mask_active),
        .output_enable(output_enable),
        .overlap_ok   (overlap_ok)
    );

endmodule

`default_nettype wire

// ==== bit_plane_timer.sv ====
/*
 * Output enable timer for binary-coded modulation
 * on-time weighted by the active bit plane, flags when overlap may start
 */
`default_nettype none

module bit_plane_timer import hub75_pkg::*; (
    input  logic    clk_in,
    input  logic    reset,
    input  logic    row_latch,
    input  colour_t mask_active,
    output logic    output_enable,
    output logic    overlap_ok
);

    logic                    armed;
    logic [on_time_bits-1:0] on_time;
    logic [on_time_bits-1:0] counter;

    // base time shifted by the index of the set mask bit
    always_comb begin
        on_time = '0;
        for (int i = 0; i < brightness_levels; i++) begin
            if (mask_active[i]) begin
                on_time = on_time_bits'(base_on_cycles) << i;
            end
        end
    end

    // armed covers the first lit cycle while mask_active settles after the latch
    always_ff @(posedge clk_in) begin
        if (reset) begin
            armed <= 1'b0;
            counter <= '0;
        end else begin
            armed <= row_latch;
            if (armed) begin
                // armed cycle already counts as one
                counter <= on_time - 1'b1;
            end else if (counter != '0) begin
                counter <= counter - 1'b1;
            end
        end
    end

    assign output_enable = armed || (counter != '0);

    // remaining time fits one plane shift plus the pipeline to the latch
    assign overlap_ok = !armed && (counter <= on_time_bits'(2 * panel_width + 4));

endmodule

`default_nettype wire

// ==== countdown_timer.sv ====
/*
 * Loadable down-counter
 * loads on start, then counts to zero and stops there
 */
`default_nettype none

module countdown_timer #(
    parameter int counter_width = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [counter_width-1:0] value,
    output logic [counter_width-1:0] counter,
    output logic                     running
);

    // start wins over the running count, so a restart reloads
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

    // still busy until the count has reached zero
    assign running = (counter != '0);

endmodule

`default_nettype wire

// ==== hub75_pkg.sv ====
/*
 * HUB75 panel driver shared definitions
 * panel geometry, modulation constants and the pipeline structs
 */
`default_nettype none

package hub75_pkg;

    // one panel, top and bottom half share the row select
    localparam int panel_width = 16;
    localparam int panel_halfheight = 4;

    // bits per colour, one bit plane per bit
    localparam int brightness_levels = 4;
    // lsb plane on-time in clk_in cycles
    localparam int base_on_cycles = 8;

    localparam int column_bits = $clog2(panel_width);
    localparam int row_bits = $clog2(panel_halfheight);
    // wide enough to hold the msb plane on-time
    localparam int on_time_bits = $clog2(base_on_cycles << (brightness_levels - 1)) + 1;

    // intensity of one colour channel
    typedef logic [brightness_levels-1:0] colour_t;

    typedef struct packed {
        colour_t red;
        colour_t green;
        colour_t blue;
    } pixel_t;

    // host write port, en is a single-cycle strobe
    typedef struct packed {
        logic en;
        logic half;
        logic [row_bits-1:0] row;
        logic [column_bits-1:0] column;
        pixel_t pixel;
    } host_wr_t;

    // load command from the scan controller
    typedef struct packed {
        logic valid;
        // column 0, final command of the plane
        logic last;
        logic [column_bits-1:0] column;
        logic [row_bits-1:0] row;
        // one-hot bit select
        colour_t mask;
    } scan_cmd_t;

    // matched top/bottom pixel pair plus the command flags
    typedef struct packed {
        logic valid;
        logic last;
        colour_t mask;
        pixel_t top;
        pixel_t bottom;
    } fetch_t;

    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
    } rgb_pins_t;

endpackage

`default_nettype wire
